// ==== flist.f ====
+incdir+tb
verilog/rv_pkg.sv
verilog/decoder.sv
verilog/imm_gen.sv
verilog/alu.sv
verilog/register_bank.sv
verilog/data_ram.sv
verilog/pc_unit.sv
verilog/riscv_core.sv
tb/tb_riscv_core.sv

// ==== tb/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Architectural state of the model
logic [31:0] ref_regs [0:31];   // x0 never written
logic [31:0] ref_ram  [0:255];
logic [31:0] ref_pc;
logic [31:0] lfsr_state;

// Reports expected for the instruction just modeled
logic        exp_wb_valid;
logic        exp_st_valid;
logic [4:0]  exp_wb_rd;
logic [31:0] exp_wb_data;
logic [31:0] exp_st_addr;
logic [31:0] exp_st_data;

// Galois LFSR stepped once per bit taken
function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
    end
    return v;
endfunction

// Executes one instruction on the model state
function automatic void model_step(input logic [31:0] ins);
    logic [6:0]  opc;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] r2;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] next_pc;
    logic        wr;
    logic        lt;
    logic        taken;
    opc     = ins[6:0];
    rd      = ins[11:7];
    f3      = ins[14:12];
    a       = ref_regs[ins[19:15]];
    r2      = ref_regs[ins[24:20]];
    b       = (opc == rv_pkg::opc_op) ? r2 : {{20{ins[31]}}, ins[31:20]};
    wr      = 1'b1;
    res     = '0;
    next_pc = ref_pc + 32'd4;
    case (opc)
        rv_pkg::opc_op, rv_pkg::opc_op_imm: begin
            case (f3)
                3'b000:  res = (opc == rv_pkg::opc_op && ins[30]) ? a - b : a + b;
                3'b001:  res = a << b[4:0];
                3'b010:  res = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
                3'b011:  res = {31'b0, a < b};
                3'b100:  res = a ^ b;
                3'b101:  res = (a >> b[4:0]) |    // Sign fill for SRA/SRAI
                               ((ins[30] && a[31]) ? ~(32'hffffffff >> b[4:0]) : '0);
                3'b110:  res = a | b;
                default: res = a & b;
            endcase
        end
        rv_pkg::opc_load: begin
            addr = a + b;
            res  = ref_ram[addr[9:2]];
        end
        rv_pkg::opc_store: begin
            wr           = 1'b0;
            addr         = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            exp_st_valid = 1'b1;
            exp_st_addr  = addr;
            exp_st_data  = r2;
            ref_ram[addr[9:2]] = r2;
        end
        rv_pkg::opc_branch: begin
            wr    = 1'b0;
            lt    = (a[31] != r2[31]) ? a[31] : (a < r2);   // Signed compare
            taken = f3[0] ^ (f3[2] ? (f3[1] ? (a < r2) : lt) : (a == r2));
            if (taken) begin
                next_pc = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
        end
        rv_pkg::opc_lui:   res = {ins[31:12], 12'h000};
        rv_pkg::opc_auipc: res = ref_pc + {ins[31:12], 12'h000};
        rv_pkg::opc_jal: begin
            res     = ref_pc + 32'd4;   // Link value
            next_pc = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        default: wr = 1'b0;             // Unknown opcode only moves the PC
    endcase
    exp_wb_valid = wr && (rd != 5'd0);
    exp_wb_rd    = rd;
    exp_wb_data  = res;
    if (exp_wb_valid) begin
        ref_regs[rd] = res;
    end
    ref_pc = next_pc;
endfunction

// Random instruction from the supported set
function automatic logic [31:0] build_instr();
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [19:0] hi;
    kind = 4'(random_bits(4));
    rd   = 5'(random_bits(3));          // Few registers so results feed later instructions
    rs1  = 5'(random_bits(3));
    rs2  = 5'(random_bits(3));
    f3   = 3'(random_bits(3));
    hi   = 20'(random_bits(20));
    f7   = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, hi[0], 5'b0} : 7'b0;
    case (kind)
        0, 1, 2: return {f7, rs2, rs1, f3, rd, rv_pkg::opc_op};
        3, 4, 5: return {(f3 == 3'b001 || f3 == 3'b101) ? f7 : hi[11:5], hi[16:12],
                         rs1, f3, rd, rv_pkg::opc_op_imm};
        6, 7:    return {hi[11:0], rs1, 3'b010, rd, rv_pkg::opc_load};
        8, 9:    return {hi[11:5], rs2, rs1, 3'b010, hi[4:0], rv_pkg::opc_store};
        10, 11:  return {hi[11:5], rs2, rs1, {f3[2] | f3[1], f3[1:0]}, hi[4:0],
                         rv_pkg::opc_branch};
        12:      return {hi, rd, rv_pkg::opc_lui};
        13:      return {hi, rd, rv_pkg::opc_auipc};
        14:      return {hi, rd, rv_pkg::opc_jal};
        default: return {8'h00, hi[3:0], 5'd0, 3'b000, rd, rv_pkg::opc_op_imm};
    endcase
endfunction

`endif

// ==== tb/tb_riscv_core.sv ====
`timescale 1ns/1ps

module tb_riscv_core;

    localparam int init_stores  = 256;
    localparam int rand_instrs  = 2000;
    localparam int reset_cycles = 4;
    localparam int clk_period   = 10;

    logic              clk;
    logic              rst_n;
    logic              instr_valid;
    rv_pkg::instr_t    instr;
    rv_pkg::word_t     pc;
    logic              wb_valid;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::word_t     wb_data;
    logic              st_valid;
    rv_pkg::word_t     st_addr;
    rv_pkg::word_t     st_data;

    `include "rv_ref_model.svh"

    riscv_core dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .st_valid    (st_valid),
        .st_addr     (st_addr),
        .st_data     (st_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // Twice the cycles the test needs
    initial begin
        #((init_stores + rand_instrs + reset_cycles) * clk_period * 2);
        $display("Timeout: the test did not finish within the expected time");
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %08h, expected %08h",
                     $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Drive on the falling edge, then check the combinational reports
    task automatic run_cycle(input logic valid, input logic [31:0] ins);
        @(negedge clk);
        instr_valid = valid;
        instr       = ins;
        #1;
        check_value(pc, ref_pc, $sformatf("pc at instr %08h", ins));
        exp_wb_valid = 1'b0;
        exp_st_valid = 1'b0;
        if (valid) begin
            model_step(ins);
        end
        check_value(32'(wb_valid), 32'(exp_wb_valid), $sformatf("wb_valid, instr %08h", ins));
        if (exp_wb_valid) begin
            check_value(32'(wb_rd), 32'(exp_wb_rd), $sformatf("wb_rd, instr %08h", ins));
            check_value(wb_data, exp_wb_data, $sformatf("wb_data, instr %08h", ins));
        end
        check_value(32'(st_valid), 32'(exp_st_valid), $sformatf("st_valid, instr %08h", ins));
        if (exp_st_valid) begin
            check_value(st_addr, exp_st_addr, $sformatf("st_addr, instr %08h", ins));
            check_value(st_data, exp_st_data, $sformatf("st_data, instr %08h", ins));
        end
    endtask

    initial begin
        logic [11:0] off;
        lfsr_state  = 32'ha073e6d9;
        ref_pc      = '0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (reset_cycles) begin
            @(posedge clk);
            #1;
            check_value(32'(wb_valid | st_valid), 32'h0, "report during reset");
        end
        @(negedge clk);
        rst_n = 1'b1;
        run_cycle(1'b0, '0);                    // pc must read 0
        // Every RAM word through SW from x0
        for (int i = 0; i < init_stores; i++) begin
            off = 12'(i * 4);
            run_cycle(1'b1, {off[11:5], 5'd0, 5'd0, 3'b010, off[4:0], rv_pkg::opc_store});
        end
        for (int n = 0; n < rand_instrs; n++) begin
            if (random_bits(3) == 0) begin
                run_cycle(1'b0, random_bits(32));   // Idle with junk on instr
            end
            run_cycle(1'b1, build_instr());
        end
        run_cycle(1'b0, '0);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_t op,
    output rv_pkg::word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Only low 5 bits count for shifts

    always_comb begin
        case (op)
            rv_pkg::alu_add: begin
                result = a + b;
            end
            rv_pkg::alu_sub: begin
                result = a - b;
            end
            rv_pkg::alu_and: begin
                result = a & b;
            end
            rv_pkg::alu_or: begin
                result = a | b;
            end
            rv_pkg::alu_xor: begin
                result = a ^ b;
            end
            rv_pkg::alu_sll: begin
                result = a << shamt;
            end
            rv_pkg::alu_srl: begin
                result = a >> shamt;
            end
            rv_pkg::alu_sra: begin
                result = $signed(a) >>> shamt;
            end
            rv_pkg::alu_slt: begin
                result = ($signed(a) < $signed(b)) ? rv_pkg::word_t'(1) : '0;
            end
            rv_pkg::alu_sltu: begin
                result = (a < b) ? rv_pkg::word_t'(1) : '0;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
    input  logic          clk,
    input  rv_pkg::word_t addr,
    input  rv_pkg::word_t wdata,
    input  logic          we,
    output rv_pkg::word_t rdata
);

    rv_pkg::word_t mem [0:rv_pkg::ram_words-1];

    logic [rv_pkg::ram_addr_bits-1:0] idx;

    // Word index, byte offset and upper address bits dropped
    assign idx = addr[rv_pkg::ram_addr_bits+1:2];

    assign rdata = mem[idx];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

endmodule

// ==== verilog/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  logic              instr_valid,
    input  rv_pkg::instr_t    instr,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::alu_op_t   alu_op,
    output logic              alu_src_imm,  // B operand from immediate
    output logic              a_sel_pc,     // A operand from PC (AUIPC)
    output logic              a_zero,       // A operand forced to zero (LUI)
    output logic              reg_write,
    output logic              mem_write,
    output rv_pkg::wb_sel_t   wb_sel,
    output logic              is_branch,
    output logic              is_jal,
    output logic [2:0]        funct3,
    output logic              pc_advance
);

    logic [6:0] opcode;
    logic       f7_alt;     // funct7 bit 5, picks SUB and SRA
    logic       wr_reg;
    logic       wr_mem;
    logic       br;
    logic       jal;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign f7_alt = instr[30];

    // Main control
    always_comb begin
        wr_reg      = 1'b0;
        wr_mem      = 1'b0;
        br          = 1'b0;
        jal         = 1'b0;
        alu_src_imm = 1'b0;
        a_sel_pc    = 1'b0;
        a_zero      = 1'b0;
        wb_sel      = rv_pkg::wb_alu;
        case (opcode)
            rv_pkg::opc_op: begin
                wr_reg = 1'b1;
            end
            rv_pkg::opc_op_imm: begin
                wr_reg      = 1'b1;
                alu_src_imm = 1'b1;
            end
            rv_pkg::opc_load: begin
                wr_reg      = 1'b1;
                alu_src_imm = 1'b1;             // Address is rs1 + offset
                wb_sel      = rv_pkg::wb_mem;
            end
            rv_pkg::opc_store: begin
                wr_mem      = 1'b1;
                alu_src_imm = 1'b1;
            end
            rv_pkg::opc_branch: begin
                br = 1'b1;
            end
            rv_pkg::opc_lui: begin
                wr_reg      = 1'b1;
                alu_src_imm = 1'b1;
                a_zero      = 1'b1;             // 0 + imm
            end
            rv_pkg::opc_auipc: begin
                wr_reg      = 1'b1;
                alu_src_imm = 1'b1;
                a_sel_pc    = 1'b1;             // pc + imm
            end
            rv_pkg::opc_jal: begin
                wr_reg = 1'b1;
                jal    = 1'b1;
                wb_sel = rv_pkg::wb_pc4;
            end
            default: ;                          // Unknown opcode acts as no-op
        endcase
    end

    // ALU control
    always_comb begin
        alu_op = rv_pkg::alu_add;
        case (opcode)
            rv_pkg::opc_op, rv_pkg::opc_op_imm: begin
                case (funct3)
                    3'b000:  alu_op = (opcode == rv_pkg::opc_op && f7_alt) ?
                                      rv_pkg::alu_sub : rv_pkg::alu_add;
                    3'b001:  alu_op = rv_pkg::alu_sll;
                    3'b010:  alu_op = rv_pkg::alu_slt;
                    3'b011:  alu_op = rv_pkg::alu_sltu;
                    3'b100:  alu_op = rv_pkg::alu_xor;
                    3'b101:  alu_op = f7_alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                    3'b110:  alu_op = rv_pkg::alu_or;
                    default: alu_op = rv_pkg::alu_and;
                endcase
            end
            rv_pkg::opc_branch: begin
                // Compare forms, the taken decision itself lives in pc_unit
                case (funct3)
                    rv_pkg::f3_beq, rv_pkg::f3_bne: alu_op = rv_pkg::alu_sub;
                    rv_pkg::f3_blt, rv_pkg::f3_bge: alu_op = rv_pkg::alu_slt;
                    default:                        alu_op = rv_pkg::alu_sltu;
                endcase
            end
            default: alu_op = rv_pkg::alu_add;  // Address and LUI/AUIPC sums
        endcase
    end

    // Strobe gating of everything that commits state
    assign reg_write  = wr_reg & instr_valid;
    assign mem_write  = wr_mem & instr_valid;
    assign is_branch  = br & instr_valid;
    assign is_jal     = jal & instr_valid;
    assign pc_advance = instr_valid;            // Every strobed instruction moves the PC

endmodule

// ==== verilog/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
    input  rv_pkg::instr_t instr,
    output rv_pkg::word_t  imm
);

    logic [6:0] opcode;

    assign opcode = instr[6:0];

    always_comb begin
        case (opcode)
            // I format
            rv_pkg::opc_op_imm, rv_pkg::opc_load:
                imm = {{20{instr[31]}}, instr[31:20]};
            // S format
            rv_pkg::opc_store:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // B format, bit 0 always zero
            rv_pkg::opc_branch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            // U format
            rv_pkg::opc_lui, rv_pkg::opc_auipc:
                imm = {instr[31:12], 12'b0};
            // J format
            rv_pkg::opc_jal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// ==== verilog/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          is_branch,
    input  logic          is_jal,
    input  logic [2:0]    funct3,
    input  logic          pc_advance,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t rs2_data,
    input  rv_pkg::word_t imm,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t pc_plus4
);

    logic          taken;
    rv_pkg::word_t pc_target;

    // Branch condition straight from the register values
    always_comb begin
        case (funct3)
            rv_pkg::f3_beq:  taken = (rs1_data == rs2_data);
            rv_pkg::f3_bne:  taken = (rs1_data != rs2_data);
            rv_pkg::f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
            rv_pkg::f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            rv_pkg::f3_bltu: taken = (rs1_data < rs2_data);
            rv_pkg::f3_bgeu: taken = (rs1_data >= rs2_data);
            default:         taken = 1'b0;  // Reserved encodings never branch
        endcase
    end

    assign pc_plus4  = pc + rv_pkg::word_t'(4);
    assign pc_target = pc + imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_advance) begin
            if (is_jal || (is_branch && taken)) begin
                pc <= pc_target;
            end else begin
                pc <= pc_plus4;
            end
        end
    end

endmodule

// ==== verilog/register_bank.sv ====
`timescale 1ns/1ps

module register_bank (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     wdata,
    input  logic              we,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);

    rv_pkg::word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin   // x0 is never written
            regs[rd] <= wdata;
        end
    end

    // Combinational reads, x0 hardwired to zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== verilog/riscv_core.sv ====
`timescale 1ns/1ps

module riscv_core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  rv_pkg::instr_t    instr,
    output rv_pkg::word_t     pc,
    output logic              wb_valid,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::word_t     wb_data,
    output logic              st_valid,
    output rv_pkg::word_t     st_addr,
    output rv_pkg::word_t     st_data
);

    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t rd;
    rv_pkg::alu_op_t   alu_op;
    rv_pkg::wb_sel_t   wb_sel;
    logic              alu_src_imm;
    logic              a_sel_pc;
    logic              a_zero;
    logic              reg_write;
    logic              mem_write;
    logic              is_branch;
    logic              is_jal;
    logic              pc_advance;
    logic [2:0]        funct3;

    rv_pkg::word_t     imm;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::word_t     alu_a;
    rv_pkg::word_t     alu_b;
    rv_pkg::word_t     result;
    rv_pkg::word_t     rdata;
    rv_pkg::word_t     pc_plus4;
    rv_pkg::word_t     rd_data;

    decoder u_decoder (
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .a_sel_pc    (a_sel_pc),
        .a_zero      (a_zero),
        .reg_write   (reg_write),
        .mem_write   (mem_write),
        .wb_sel      (wb_sel),
        .is_branch   (is_branch),
        .is_jal      (is_jal),
        .funct3      (funct3),
        .pc_advance  (pc_advance)
    );

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    register_bank u_register_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .wdata    (rd_data),
        .we       (reg_write),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // Operand A: zero for LUI, PC for AUIPC, else rs1
    assign alu_a = a_zero   ? '0 :
                   a_sel_pc ? pc : rs1_data;
    assign alu_b = alu_src_imm ? imm : rs2_data;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (result)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .addr  (result),    // rs1 + offset
        .wdata (rs2_data),
        .we    (mem_write),
        .rdata (rdata)
    );

    pc_unit u_pc_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .is_branch  (is_branch),
        .is_jal     (is_jal),
        .funct3     (funct3),
        .pc_advance (pc_advance),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .pc         (pc),
        .pc_plus4   (pc_plus4)
    );

    // Write-back source select
    assign rd_data = (wb_sel == rv_pkg::wb_mem) ? rdata    :
                     (wb_sel == rv_pkg::wb_pc4) ? pc_plus4 : result;

    // Commit reports
    assign wb_valid = reg_write && (rd != '0);
    assign wb_rd    = rd;
    assign wb_data  = rd_data;
    assign st_valid = mem_write;
    assign st_addr  = result;
    assign st_data  = rs2_data;

endmodule

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 32;

    // Word-sized values: registers, operands, PC, memory data
    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      alu_op_t;
    typedef logic [1:0]      wb_sel_t;

    // ALU operation codes
    localparam alu_op_t alu_add  = 4'b0000;
    localparam alu_op_t alu_sub  = 4'b0001;
    localparam alu_op_t alu_and  = 4'b0010;
    localparam alu_op_t alu_or   = 4'b0011;
    localparam alu_op_t alu_xor  = 4'b0100;
    localparam alu_op_t alu_sltu = 4'b1001;
    localparam alu_op_t alu_slt  = 4'b1010;
    localparam alu_op_t alu_sll  = 4'b1101;
    localparam alu_op_t alu_srl  = 4'b1110;
    localparam alu_op_t alu_sra  = 4'b1111;

    // Major opcodes of the supported subset
    localparam logic [6:0] opc_op     = 7'b0110011;  // R-type
    localparam logic [6:0] opc_op_imm = 7'b0010011;  // I-type ALU
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    // Branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Write-back source
    localparam wb_sel_t wb_alu = 2'd0;
    localparam wb_sel_t wb_mem = 2'd1;
    localparam wb_sel_t wb_pc4 = 2'd2;  // Link value for JAL

    // Data RAM size in words
    localparam int ram_words     = 256;
    localparam int ram_addr_bits = 8;

endpackage
